// ==== mem_subsys_top.f ====
rtl/core_pkg.sv
rtl/stall_ctrl.sv
rtl/ex_mem_reg.sv
rtl/mem_stage.sv
rtl/dmem.sv
rtl/mem_wb_reg.sv
rtl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// ==== rtl/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 64;
    localparam int XLEN_BYTES = XLEN / 8;
    localparam int NUM_STAGES = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [63:0]           pc_t;
    typedef logic [31:0]           inst_t;
    typedef logic [4:0]            reg_addr_t;
    typedef logic [63:0]           daddr_t;
    typedef logic [2:0]            ls_sel_t;
    typedef logic [7:0]            inst_type_t;
    typedef logic [NUM_STAGES-1:0] stall_vec_t;  // bit 0 is pc, bit 4 is mem
    typedef logic [XLEN_BYTES-1:0] strb_t;

    // class flag positions inside inst_type
    localparam int ITYPE_LOAD_BIT  = 1;
    localparam int ITYPE_STORE_BIT = 2;

    localparam int STAGE_EX  = 3;
    localparam int STAGE_MEM = 4;

    // load/store selector follows the funct3 coding
    localparam ls_sel_t LS_B  = 3'd0;
    localparam ls_sel_t LS_H  = 3'd1;
    localparam ls_sel_t LS_W  = 3'd2;
    localparam ls_sel_t LS_D  = 3'd3;
    localparam ls_sel_t LS_BU = 3'd4;
    localparam ls_sel_t LS_HU = 3'd5;
    localparam ls_sel_t LS_WU = 3'd6;

    // the data ram is word addressed, so the index starts above the byte offset
    localparam int DMEM_WORDS   = 512;
    localparam int DMEM_IDX_W   = 9;
    localparam int DMEM_IDX_LSB = 3;

    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT  // read issued, data arrives this cycle
    } mem_state_t;

endpackage

// ==== rtl/dmem.sv ====
`timescale 1ns/1ps

module dmem (
    input  logic                            clk,
    input  logic                            en_i,
    input  logic                            we_i,
    input  logic [core_pkg::DMEM_IDX_W-1:0] idx_i,
    input  core_pkg::xlen_t                 wdata_i,
    input  core_pkg::strb_t                 wstrb_i,
    output core_pkg::xlen_t                 rdata_o
);

    core_pkg::xlen_t mem_q [core_pkg::DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < core_pkg::XLEN_BYTES; b++) begin
                    if (wstrb_i[b]) begin
                        mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem_q[idx_i];  // read data is held until the next read
            end
        end
    end

endmodule

// ==== rtl/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  core_pkg::stall_vec_t   stall_vec_i,

    input  core_pkg::pc_t          ex_pc_i,
    input  core_pkg::inst_t        ex_inst_i,
    input  core_pkg::inst_type_t   ex_inst_type_i,
    input  logic                   ex_rd_ena_i,
    input  core_pkg::xlen_t        ex_rd_data_i,
    input  core_pkg::reg_addr_t    ex_rd_addr_i,
    input  core_pkg::ls_sel_t      ex_ls_sel_i,
    input  core_pkg::daddr_t       ex_ls_addr_i,

    output core_pkg::pc_t          mem_pc_o,
    output core_pkg::inst_t        mem_inst_o,
    output core_pkg::inst_type_t   mem_inst_type_o,
    output logic                   mem_rd_ena_o,
    output core_pkg::xlen_t        mem_rd_data_o,
    output core_pkg::reg_addr_t    mem_rd_addr_o,
    output core_pkg::ls_sel_t      mem_ls_sel_o,
    output core_pkg::daddr_t       mem_ls_addr_o
);

    logic hold;
    logic bubble;

    assign hold   = stall_vec_i[core_pkg::STAGE_MEM];
    assign bubble = stall_vec_i[core_pkg::STAGE_EX] & ~hold;  // ex frozen but mem moving on

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_pc_o        <= '0;
            mem_inst_o      <= '0;
            mem_inst_type_o <= '0;
            mem_rd_ena_o    <= 1'b0;
            mem_rd_data_o   <= '0;
            mem_rd_addr_o   <= '0;
            mem_ls_sel_o    <= '0;
            mem_ls_addr_o   <= '0;
        end else if (bubble) begin
            // an all zero entry has no class flags and no register write
            mem_pc_o        <= '0;
            mem_inst_o      <= '0;
            mem_inst_type_o <= '0;
            mem_rd_ena_o    <= 1'b0;
            mem_rd_data_o   <= '0;
            mem_rd_addr_o   <= '0;
            mem_ls_sel_o    <= '0;
            mem_ls_addr_o   <= '0;
        end else if (!hold) begin
            mem_pc_o        <= ex_pc_i;
            mem_inst_o      <= ex_inst_i;
            mem_inst_type_o <= ex_inst_type_i;
            mem_rd_ena_o    <= ex_rd_ena_i;
            mem_rd_data_o   <= ex_rd_data_i;
            mem_rd_addr_o   <= ex_rd_addr_i;
            mem_ls_sel_o    <= ex_ls_sel_i;
            mem_ls_addr_o   <= ex_ls_addr_i;
        end
    end

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                              clk,
    input  logic                              arst_n_i,

    input  core_pkg::inst_type_t              mem_inst_type_i,
    input  logic                              mem_rd_ena_i,
    input  core_pkg::xlen_t                   mem_rd_data_i,
    input  core_pkg::reg_addr_t               mem_rd_addr_i,
    input  core_pkg::ls_sel_t                 mem_ls_sel_i,
    input  core_pkg::daddr_t                  mem_ls_addr_i,
    input  core_pkg::xlen_t                   dmem_rdata_i,

    output logic                              dmem_en_o,
    output logic                              dmem_we_o,
    output logic [core_pkg::DMEM_IDX_W-1:0]   dmem_idx_o,
    output core_pkg::xlen_t                   dmem_wdata_o,
    output core_pkg::strb_t                   dmem_wstrb_o,
    output logic                              mem_stall_req_o,

    output logic                              wb_rd_ena_o,
    output core_pkg::reg_addr_t               wb_rd_addr_o,
    output core_pkg::xlen_t                   wb_rd_data_o
);

    core_pkg::mem_state_t state_q;
    core_pkg::mem_state_t state_d;
    logic                 is_load;
    logic                 is_store;
    logic [2:0]           lane_off;
    core_pkg::strb_t      size_mask;
    core_pkg::xlen_t      rdata_shifted;
    core_pkg::xlen_t      load_data;

    assign is_load  = mem_inst_type_i[core_pkg::ITYPE_LOAD_BIT];
    assign is_store = mem_inst_type_i[core_pkg::ITYPE_STORE_BIT];

    // address bits below the access size are dropped, so every access is aligned
    always_comb begin
        case (mem_ls_sel_i)
            core_pkg::LS_B, core_pkg::LS_BU: begin
                lane_off  = mem_ls_addr_i[2:0];
                size_mask = 8'h01;
            end
            core_pkg::LS_H, core_pkg::LS_HU: begin
                lane_off  = {mem_ls_addr_i[2:1], 1'b0};
                size_mask = 8'h03;
            end
            core_pkg::LS_W, core_pkg::LS_WU: begin
                lane_off  = {mem_ls_addr_i[2], 2'b00};
                size_mask = 8'h0f;
            end
            core_pkg::LS_D: begin
                lane_off  = 3'd0;
                size_mask = 8'hff;
            end
            default: begin
                lane_off  = 3'd0;
                size_mask = 8'hff;
            end
        endcase
    end

    always_comb begin
        state_d         = state_q;
        mem_stall_req_o = 1'b0;
        case (state_q)
            core_pkg::MEM_IDLE: begin
                if (is_load) begin
                    state_d         = core_pkg::MEM_WAIT;
                    mem_stall_req_o = 1'b1;  // keep the load in ex/mem one more cycle
                end
            end
            default: state_d = core_pkg::MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= core_pkg::MEM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign dmem_en_o    = is_store | (is_load & (state_q == core_pkg::MEM_IDLE));
    assign dmem_we_o    = is_store;
    assign dmem_idx_o   = mem_ls_addr_i[core_pkg::DMEM_IDX_LSB +: core_pkg::DMEM_IDX_W];
    assign dmem_wdata_o = mem_rd_data_i << {lane_off, 3'b000};  // store data rides in rd_data
    assign dmem_wstrb_o = size_mask << lane_off;

    assign rdata_shifted = dmem_rdata_i >> {lane_off, 3'b000};

    always_comb begin
        case (mem_ls_sel_i)
            core_pkg::LS_B:  load_data = {{56{rdata_shifted[7]}}, rdata_shifted[7:0]};
            core_pkg::LS_H:  load_data = {{48{rdata_shifted[15]}}, rdata_shifted[15:0]};
            core_pkg::LS_W:  load_data = {{32{rdata_shifted[31]}}, rdata_shifted[31:0]};
            core_pkg::LS_BU: load_data = {56'd0, rdata_shifted[7:0]};
            core_pkg::LS_HU: load_data = {48'd0, rdata_shifted[15:0]};
            core_pkg::LS_WU: load_data = {32'd0, rdata_shifted[31:0]};
            default:         load_data = rdata_shifted;
        endcase
    end

    // stores never write a register, whatever rd_ena says
    assign wb_rd_ena_o  = mem_rd_ena_i & ~is_store;
    assign wb_rd_addr_o = mem_rd_addr_i;
    assign wb_rd_data_o = is_load ? load_data : mem_rd_data_i;

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   ex_stall_req_i,

    input  core_pkg::pc_t          ex_pc_i,
    input  core_pkg::inst_t        ex_inst_i,
    input  core_pkg::inst_type_t   ex_inst_type_i,
    input  logic                   ex_rd_ena_i,
    input  core_pkg::xlen_t        ex_rd_data_i,
    input  core_pkg::reg_addr_t    ex_rd_addr_i,
    input  core_pkg::ls_sel_t      ex_ls_sel_i,
    input  core_pkg::daddr_t       ex_ls_addr_i,

    output core_pkg::stall_vec_t   stall_ctrl_o,  // also freezes the upstream stages
    output core_pkg::pc_t          wb_pc_o,
    output core_pkg::inst_t        wb_inst_o,
    output logic                   wb_rd_ena_o,
    output core_pkg::reg_addr_t    wb_rd_addr_o,
    output core_pkg::xlen_t        wb_rd_data_o
);

    logic                            mem_stall_req;

    core_pkg::pc_t                   mem_pc;
    core_pkg::inst_t                 mem_inst;
    core_pkg::inst_type_t            mem_inst_type;
    logic                            mem_rd_ena;
    core_pkg::xlen_t                 mem_rd_data;
    core_pkg::reg_addr_t             mem_rd_addr;
    core_pkg::ls_sel_t               mem_ls_sel;
    core_pkg::daddr_t                mem_ls_addr;

    logic                            dmem_en;
    logic                            dmem_we;
    logic [core_pkg::DMEM_IDX_W-1:0] dmem_idx;
    core_pkg::xlen_t                 dmem_wdata;
    core_pkg::strb_t                 dmem_wstrb;
    core_pkg::xlen_t                 dmem_rdata;

    // mem stage results on their way into the mem/wb register
    logic                            ms_rd_ena;
    core_pkg::reg_addr_t             ms_rd_addr;
    core_pkg::xlen_t                 ms_rd_data;

    stall_ctrl u_stall_ctrl (
        .ex_stall_req_i  (ex_stall_req_i),
        .mem_stall_req_i (mem_stall_req),
        .stall_vec_o     (stall_ctrl_o)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_vec_i     (stall_ctrl_o),
        .ex_pc_i         (ex_pc_i),
        .ex_inst_i       (ex_inst_i),
        .ex_inst_type_i  (ex_inst_type_i),
        .ex_rd_ena_i     (ex_rd_ena_i),
        .ex_rd_data_i    (ex_rd_data_i),
        .ex_rd_addr_i    (ex_rd_addr_i),
        .ex_ls_sel_i     (ex_ls_sel_i),
        .ex_ls_addr_i    (ex_ls_addr_i),
        .mem_pc_o        (mem_pc),
        .mem_inst_o      (mem_inst),
        .mem_inst_type_o (mem_inst_type),
        .mem_rd_ena_o    (mem_rd_ena),
        .mem_rd_data_o   (mem_rd_data),
        .mem_rd_addr_o   (mem_rd_addr),
        .mem_ls_sel_o    (mem_ls_sel),
        .mem_ls_addr_o   (mem_ls_addr)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .mem_inst_type_i (mem_inst_type),
        .mem_rd_ena_i    (mem_rd_ena),
        .mem_rd_data_i   (mem_rd_data),
        .mem_rd_addr_i   (mem_rd_addr),
        .mem_ls_sel_i    (mem_ls_sel),
        .mem_ls_addr_i   (mem_ls_addr),
        .dmem_rdata_i    (dmem_rdata),
        .dmem_en_o       (dmem_en),
        .dmem_we_o       (dmem_we),
        .dmem_idx_o      (dmem_idx),
        .dmem_wdata_o    (dmem_wdata),
        .dmem_wstrb_o    (dmem_wstrb),
        .mem_stall_req_o (mem_stall_req),
        .wb_rd_ena_o     (ms_rd_ena),
        .wb_rd_addr_o    (ms_rd_addr),
        .wb_rd_data_o    (ms_rd_data)
    );

    dmem u_dmem (
        .clk     (clk),
        .en_i    (dmem_en),
        .we_i    (dmem_we),
        .idx_i   (dmem_idx),
        .wdata_i (dmem_wdata),
        .wstrb_i (dmem_wstrb),
        .rdata_o (dmem_rdata)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_vec_i  (stall_ctrl_o),
        .pc_i         (mem_pc),
        .inst_i       (mem_inst),
        .rd_ena_i     (ms_rd_ena),
        .rd_addr_i    (ms_rd_addr),
        .rd_data_i    (ms_rd_data),
        .wb_pc_o      (wb_pc_o),
        .wb_inst_o    (wb_inst_o),
        .wb_rd_ena_o  (wb_rd_ena_o),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_rd_data_o (wb_rd_data_o)
    );

endmodule

// ==== rtl/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  core_pkg::stall_vec_t  stall_vec_i,

    input  core_pkg::pc_t         pc_i,
    input  core_pkg::inst_t       inst_i,
    input  logic                  rd_ena_i,
    input  core_pkg::reg_addr_t   rd_addr_i,
    input  core_pkg::xlen_t       rd_data_i,

    output core_pkg::pc_t         wb_pc_o,
    output core_pkg::inst_t       wb_inst_o,
    output logic                  wb_rd_ena_o,
    output core_pkg::reg_addr_t   wb_rd_addr_o,
    output core_pkg::xlen_t       wb_rd_data_o
);

    // a stalled mem stage sends nothing forward, so each entry retires once
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_pc_o      <= '0;
            wb_inst_o    <= '0;
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
        end else if (stall_vec_i[core_pkg::STAGE_MEM]) begin
            wb_pc_o      <= '0;
            wb_inst_o    <= '0;
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
        end else begin
            wb_pc_o      <= pc_i;
            wb_inst_o    <= inst_i;
            wb_rd_ena_o  <= rd_ena_i;
            wb_rd_addr_o <= rd_addr_i;
            wb_rd_data_o <= rd_data_i;
        end
    end

endmodule

// ==== rtl/stall_ctrl.sv ====
`timescale 1ns/1ps

module stall_ctrl (
    input  logic                 ex_stall_req_i,
    input  logic                 mem_stall_req_i,
    output core_pkg::stall_vec_t stall_vec_o
);

    // a request from stage k freezes stage k and everything before it
    localparam core_pkg::stall_vec_t STOP_UP_TO_EX  =
        core_pkg::stall_vec_t'((1 << (core_pkg::STAGE_EX + 1)) - 1);
    localparam core_pkg::stall_vec_t STOP_UP_TO_MEM =
        core_pkg::stall_vec_t'((1 << (core_pkg::STAGE_MEM + 1)) - 1);

    always_comb begin
        if (mem_stall_req_i) begin
            stall_vec_o = STOP_UP_TO_MEM;  // mem wins over ex
        end else if (ex_stall_req_i) begin
            stall_vec_o = STOP_UP_TO_EX;
        end else begin
            stall_vec_o = '0;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_mem_subsys \
    -f mem_subsys_top.f

sim_out=$(./obj_dir/Vtb_mem_subsys)
echo "$sim_out"

if echo "$sim_out" | grep -qxF "=== PASS ==="; then
    exit 0
fi
exit 1

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int         WB_TIMEOUT = 20;
    localparam int         RAND_PAIRS = 24;
    localparam logic [1:0] KIND_ALU   = 2'd0;
    localparam logic [1:0] KIND_LOAD  = 2'd1;
    localparam logic [1:0] KIND_STORE = 2'd2;

    typedef struct packed {
        logic [1:0]          kind;
        core_pkg::ls_sel_t   sel;
        core_pkg::daddr_t    addr;
        core_pkg::xlen_t     data;      // alu result or store data
        core_pkg::reg_addr_t rd;
        logic [3:0]          stall;     // cycles of ex_stall_req before release
        logic                exp_ena;
        core_pkg::xlen_t     exp_data;
    } row_t;

    logic                 clk = 1'b0;
    logic                 arst_n_i;
    logic                 ex_stall_req_i;
    core_pkg::pc_t        ex_pc_i;
    core_pkg::inst_t      ex_inst_i;
    core_pkg::inst_type_t ex_inst_type_i;
    logic                 ex_rd_ena_i;
    core_pkg::xlen_t      ex_rd_data_i;
    core_pkg::reg_addr_t  ex_rd_addr_i;
    core_pkg::ls_sel_t    ex_ls_sel_i;
    core_pkg::daddr_t     ex_ls_addr_i;
    core_pkg::stall_vec_t stall_ctrl_o;
    core_pkg::pc_t        wb_pc_o;
    core_pkg::inst_t      wb_inst_o;
    logic                 wb_rd_ena_o;
    core_pkg::reg_addr_t  wb_rd_addr_o;
    core_pkg::xlen_t      wb_rd_data_o;

    row_t        rows[$];
    logic [7:0]  shadow [4096];  // byte image of the 4 KiB window the ram decodes
    logic [31:0] lfsr_state = 32'h336570e9;
    int          check_errors = 0;
    int          timeout_errors = 0;

    mem_subsys_top dut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .ex_stall_req_i (ex_stall_req_i),
        .ex_pc_i        (ex_pc_i),
        .ex_inst_i      (ex_inst_i),
        .ex_inst_type_i (ex_inst_type_i),
        .ex_rd_ena_i    (ex_rd_ena_i),
        .ex_rd_data_i   (ex_rd_data_i),
        .ex_rd_addr_i   (ex_rd_addr_i),
        .ex_ls_sel_i    (ex_ls_sel_i),
        .ex_ls_addr_i   (ex_ls_addr_i),
        .stall_ctrl_o   (stall_ctrl_o),
        .wb_pc_o        (wb_pc_o),
        .wb_inst_o      (wb_inst_o),
        .wb_rd_ena_o    (wb_rd_ena_o),
        .wb_rd_addr_o   (wb_rd_addr_o),
        .wb_rd_data_o   (wb_rd_data_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] galois_step(logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};  // one step per bit
        end
        return v;
    endfunction

    function automatic int size_bytes(core_pkg::ls_sel_t sel);
        return 1 << sel[1:0];
    endfunction

    // the access is aligned down to its own size inside the 4 KiB window
    function automatic logic [11:0] aligned_base(core_pkg::daddr_t addr, core_pkg::ls_sel_t sel);
        logic [11:0] mask;
        mask = 12'(size_bytes(sel) - 1);
        return addr[11:0] & ~mask;
    endfunction

    task automatic shadow_store(core_pkg::daddr_t addr, core_pkg::ls_sel_t sel,
                                core_pkg::xlen_t data);
        logic [11:0] base;
        base = aligned_base(addr, sel);
        for (int b = 0; b < size_bytes(sel); b++) begin
            shadow[base + 12'(b)] = data[b*8 +: 8];  // little endian
        end
    endtask

    function automatic core_pkg::xlen_t shadow_load(core_pkg::daddr_t addr,
                                                    core_pkg::ls_sel_t sel);
        logic [11:0]     base;
        core_pkg::xlen_t v;
        logic            fill;
        int              n;
        base = aligned_base(addr, sel);
        n    = size_bytes(sel);
        v    = '0;
        for (int b = n - 1; b >= 0; b--) begin
            v = {v[55:0], shadow[base + 12'(b)]};
        end
        // sel bit 2 marks the unsigned loads
        fill = ~sel[2] & shadow[base + 12'(n - 1)][7];
        for (int b = n; b < 8; b++) begin
            v[b*8 +: 8] = {8{fill}};
        end
        return v;
    endfunction

    function automatic core_pkg::inst_type_t type_flags(logic [1:0] kind);
        case (kind)
            KIND_LOAD:  return core_pkg::inst_type_t'(1 << core_pkg::ITYPE_LOAD_BIT);
            KIND_STORE: return core_pkg::inst_type_t'(1 << core_pkg::ITYPE_STORE_BIT);
            default:    return 8'h01;
        endcase
    endfunction

    function automatic core_pkg::pc_t row_pc(int idx);
        return 64'h0000_0000_8000_0000 + 64'(idx) * 64'd4;
    endfunction

    function automatic core_pkg::inst_t row_inst(int idx);
        return 32'h1000_0000 + 32'(idx);
    endfunction

    task automatic add_row(logic [1:0] kind, core_pkg::ls_sel_t sel, core_pkg::daddr_t addr,
                           core_pkg::xlen_t data, core_pkg::reg_addr_t rd, logic [3:0] stall);
        row_t r;
        r.kind     = kind;
        r.sel      = sel;
        r.addr     = addr;
        r.data     = data;
        r.rd       = rd;
        r.stall    = stall;
        r.exp_ena  = (kind != KIND_STORE);
        r.exp_data = data;
        if (kind == KIND_STORE) begin
            shadow_store(addr, sel, data);
        end
        if (kind == KIND_LOAD) begin
            r.exp_data = shadow_load(addr, sel);
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        core_pkg::daddr_t a;
        add_row(KIND_ALU, 3'd0, 64'd0, 64'h0123_4567_89ab_cdef, 5'd1, 4'd0);
        add_row(KIND_ALU, 3'd0, 64'd0, 64'hffff_0000_dead_beef, 5'd31, 4'd3);
        // known contents for 0x100 to 0x13f before anything reads them
        for (int w = 0; w < 8; w++) begin
            add_row(KIND_STORE, core_pkg::LS_D, 64'h100 + 64'(w * 8), rand_bits(64), 5'd0, 4'd0);
        end
        add_row(KIND_STORE, core_pkg::LS_B, 64'h103, 64'h0000_0000_0000_0080, 5'd0, 4'd0);
        add_row(KIND_STORE, core_pkg::LS_H, 64'h10b, 64'h0000_0000_0000_8001, 5'd0, 4'd0);
        add_row(KIND_STORE, core_pkg::LS_W, 64'h116, 64'h0000_0000_fedc_ba98, 5'd0, 4'd1);
        add_row(KIND_STORE, core_pkg::LS_D, 64'h1118, 64'h8765_4321_0fed_cba9, 5'd0, 4'd0);
        for (int s = 0; s < 7; s++) begin
            add_row(KIND_LOAD, core_pkg::ls_sel_t'(s), 64'h103, 64'd0, 5'd2, 4'd0);
            add_row(KIND_LOAD, core_pkg::ls_sel_t'(s), 64'h10a, 64'd0, 5'd3, 4'd0);
            add_row(KIND_LOAD, core_pkg::ls_sel_t'(s), 64'h114, 64'd0, 5'd4, 4'(s % 2));
            add_row(KIND_LOAD, core_pkg::ls_sel_t'(s), 64'h11c, 64'd0, 5'd5, 4'd0);
        end
        for (int p = 0; p < RAND_PAIRS; p++) begin
            a = 64'h100 + rand_bits(6);
            add_row(KIND_STORE, core_pkg::ls_sel_t'(rand_bits(2)), a, rand_bits(64), 5'd0,
                    4'(rand_bits(1)));
            a = (a & ~64'h7) | rand_bits(3);
            add_row(KIND_LOAD, core_pkg::ls_sel_t'(rand_bits(3) % 64'd7), a, 64'd0,
                    core_pkg::reg_addr_t'(rand_bits(5)), 4'(rand_bits(1)));
        end
    endtask

    task automatic drive_row(row_t r, int idx);
        ex_pc_i        <= row_pc(idx);
        ex_inst_i      <= row_inst(idx);
        ex_inst_type_i <= type_flags(r.kind);
        ex_rd_ena_i    <= 1'b1;  // stores raise it too and the mem stage has to drop it
        ex_rd_data_i   <= (r.kind == KIND_LOAD) ? 64'd0 : r.data;
        ex_rd_addr_i   <= r.rd;
        ex_ls_sel_i    <= r.sel;
        ex_ls_addr_i   <= r.addr;
        ex_stall_req_i <= (r.stall != 4'd0);
    endtask

    task automatic drive_idle();
        ex_pc_i        <= '0;
        ex_inst_i      <= '0;
        ex_inst_type_i <= '0;
        ex_rd_ena_i    <= 1'b0;
        ex_rd_data_i   <= '0;
        ex_rd_addr_i   <= '0;
        ex_ls_sel_i    <= '0;
        ex_ls_addr_i   <= '0;
        ex_stall_req_i <= 1'b0;
    endtask

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            check_errors++;
        end
    endtask

    task automatic run_row(int idx);
        row_t          r;
        core_pkg::pc_t pc;
        int            edges;
        int            ones;
        int            exp_edges;
        logic          found;
        r         = rows[idx];
        pc        = row_pc(idx);
        exp_edges = (r.kind == KIND_LOAD) ? 3 : 2;
        @(posedge clk);
        drive_row(r, idx);
        for (int k = 0; k < int'(r.stall); k++) begin
            @(negedge clk);
            check_val("stall_ctrl_o", 64'(stall_ctrl_o), 64'h0f);
            check_val("wb_rd_ena_o", 64'(wb_rd_ena_o), 64'h0);
            @(posedge clk);
            if (k == int'(r.stall) - 1) begin
                ex_stall_req_i <= 1'b0;  // inputs stay put, the next edge samples them
            end
        end
        edges = 0;
        ones  = 0;
        found = 1'b0;
        while (!found && edges < WB_TIMEOUT) begin
            @(posedge clk);
            edges++;
            if (edges == 1) begin
                drive_idle();
            end
            @(negedge clk);
            if (stall_ctrl_o == 5'h1f) begin
                ones++;
            end
            if (wb_pc_o == pc) begin
                found = 1'b1;
            end else begin
                check_val("wb_rd_ena_o", 64'(wb_rd_ena_o), 64'h0);
            end
        end
        if (!found) begin
            $display("timeout: pc %h did not reach write-back in %0d cycles", pc, WB_TIMEOUT);
            timeout_errors++;
        end else begin
            if (edges != exp_edges || ones != ((r.kind == KIND_LOAD) ? 1 : 0)) begin
                $display("pc %h reached write-back after %0d edges with %0d full stall cycles",
                         pc, edges, ones);
                check_errors++;
            end
            check_val("wb_inst_o", 64'(wb_inst_o), 64'(row_inst(idx)));
            check_val("wb_rd_ena_o", 64'(wb_rd_ena_o), 64'(r.exp_ena));
            if (r.exp_ena) begin
                check_val("wb_rd_addr_o", 64'(wb_rd_addr_o), 64'(r.rd));
                check_val("wb_rd_data_o", wb_rd_data_o, r.exp_data);
            end
            @(posedge clk);
            @(negedge clk);
            if (wb_pc_o == pc) begin
                $display("pc %h was written back more than once", pc);
                check_errors++;
            end
        end
    endtask

    initial begin
        arst_n_i <= 1'b0;
        drive_idle();
        build_table();
        repeat (16) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_val("stall_ctrl_o", 64'(stall_ctrl_o), 64'h0);
        check_val("wb_rd_ena_o", 64'(wb_rd_ena_o), 64'h0);
        for (int i = 0; i < rows.size() && timeout_errors == 0; i++) begin
            run_row(i);
        end
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
